/* design/gpu_arch_pkg.sv */
`default_nettype none

// Core geometry and program counter layout
package gpu_arch_pkg;

	// Defaults picked up by the top level
	localparam int DEF_NUM_WARPS = 4;
	localparam int DEF_NUM_THREADS = 4;
	localparam int DEF_NUM_BARRIERS = 4;

	// Program counter
	localparam int PC_WIDTH = 32;

	// Boot address of warp 0
	localparam logic [PC_WIDTH-1:0] START_PC = 32'h8000_0000;

	// One instruction word per issue
	localparam int unsigned PC_STEP = 4;

endpackage

`default_nettype wire

/* design/warp_ctl_pkg.sv */
`default_nettype none

// Control events reported by execute
package warp_ctl_pkg;

	typedef enum logic [3:0] {
		CTL_NONE    = 4'd0,
		CTL_SPAWN   = 4'd1,
		CTL_HALT    = 4'd2,
		CTL_WSTALL  = 4'd3,
		CTL_TMC     = 4'd4,
		// Divergence handling, split pushes and join pops
		CTL_SPLIT   = 4'd5,
		CTL_JOIN    = 4'd6,
		// Taken bit selects the redirect
		CTL_BRANCH  = 4'd7,
		CTL_BARRIER = 4'd8
	} ctl_op_e;

endpackage

`default_nettype wire

/* design/warp_ctl_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One control event per cycle, single-cycle strobe
interface warp_ctl_if #(
	parameter int NUM_WARPS = gpu_arch_pkg::DEF_NUM_WARPS,
	parameter int NUM_THREADS = gpu_arch_pkg::DEF_NUM_THREADS,
	parameter int NUM_BARRIERS = gpu_arch_pkg::DEF_NUM_BARRIERS
);
	import gpu_arch_pkg::*;
	import warp_ctl_pkg::*;

	localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;
	localparam int BID_W = (NUM_BARRIERS > 1) ? $clog2(NUM_BARRIERS) : 1;
	localparam int CNT_W = $clog2(NUM_WARPS + 1);

	logic valid;
	ctl_op_e op;
	logic [WID_W-1:0] warp;
	logic [NUM_THREADS-1:0] mask;
	logic [NUM_THREADS-1:0] later_mask;
	logic [PC_WIDTH-1:0] pc;
	logic taken;
	logic [BID_W-1:0] barrier_id;
	// Warp count for spawn, arrival target for barrier
	logic [CNT_W-1:0] count;

	modport src (output valid, op, warp, mask, later_mask, pc, taken, barrier_id, count);
	modport tbl (input valid, op, warp, mask, later_mask, pc, taken, count);
	modport barrier (input valid, op, warp, barrier_id, count);
endinterface

`default_nettype wire

/* design/ipdom_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module ipdom_stack #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input wire clk,
	input wire reset,
	input wire push,
	input wire pop,
	input wire [WIDTH-1:0] push_lo,
	input wire [WIDTH-1:0] push_hi,
	output logic [WIDTH-1:0] top
);
	localparam int PTR_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] entries [DEPTH];
	logic [PTR_W-1:0] sp;
	logic [PTR_W-1:0] top_idx;
	logic [PTR_W-1:0] next_idx;

	// sp counts stored entries
	assign top_idx = sp - PTR_W'(1);
	assign next_idx = sp + PTR_W'(1);
	assign top = entries[top_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			sp <= '0;
		end else if (push) begin
			sp <= sp + PTR_W'(2);
		end else if (pop) begin
			sp <= top_idx;
		end
	end

	// Fall-through entry below, second entry on top
	always_ff @(posedge clk) begin
		if (push) begin
			entries[sp] <= push_lo;
			entries[next_idx] <= push_hi;
		end
	end

endmodule

`default_nettype wire

/* design/barrier_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module barrier_unit #(
	parameter int NUM_WARPS = gpu_arch_pkg::DEF_NUM_WARPS,
	parameter int NUM_BARRIERS = gpu_arch_pkg::DEF_NUM_BARRIERS,
	localparam int CNT_W = $clog2(NUM_WARPS + 1)
) (
	input wire clk,
	input wire reset,
	warp_ctl_if.barrier ctl,
	output logic [NUM_WARPS-1:0] barrier_wait
);
	import warp_ctl_pkg::*;

	logic [NUM_WARPS-1:0] wait_mask [NUM_BARRIERS];
	logic [NUM_WARPS-1:0] cur_mask;
	logic [CNT_W-1:0] wait_cnt;
	logic arrive;
	logic release_all;

	assign arrive = ctl.valid && (ctl.op == CTL_BARRIER);
	assign cur_mask = wait_mask[ctl.barrier_id];

	// Warps already parked on the addressed barrier
	always_comb begin
		wait_cnt = '0;
		for (int i = 0; i < NUM_WARPS; i++) begin
			wait_cnt = wait_cnt + CNT_W'(cur_mask[i]);
		end
	end

	// Last arrival frees everyone and never waits itself
	assign release_all = (wait_cnt + CNT_W'(1)) == ctl.count;

	always_comb begin
		barrier_wait = '0;
		for (int b = 0; b < NUM_BARRIERS; b++) begin
			barrier_wait = barrier_wait | wait_mask[b];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int b = 0; b < NUM_BARRIERS; b++) begin
				wait_mask[b] <= '0;
			end
		end else if (arrive) begin
			if (release_all) begin
				wait_mask[ctl.barrier_id] <= '0;
			end else begin
				wait_mask[ctl.barrier_id][ctl.warp] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/warp_table.sv */
`timescale 1ns/1ps
`default_nettype none

module warp_table #(
	parameter int NUM_WARPS = gpu_arch_pkg::DEF_NUM_WARPS,
	parameter int NUM_THREADS = gpu_arch_pkg::DEF_NUM_THREADS,
	localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
	input wire clk,
	input wire reset,
	warp_ctl_if.tbl ctl,
	input wire [NUM_WARPS-1:0] barrier_wait,
	input wire pick_valid,
	input wire [WID_W-1:0] pick_warp,
	input wire fetch_stall,
	input wire issue_take,
	input wire release_valid,
	input wire [WID_W-1:0] release_warp,
	output logic [NUM_WARPS-1:0] eligible,
	output logic issue_valid,
	output logic [gpu_arch_pkg::PC_WIDTH-1:0] issue_pc,
	output logic [NUM_THREADS-1:0] issue_mask,
	output logic all_halted
);
	import gpu_arch_pkg::*;
	import warp_ctl_pkg::*;

	localparam int CNT_W = $clog2(NUM_WARPS + 1);
	// {fall-through, pc, mask}
	localparam int ENTRY_W = 1 + PC_WIDTH + NUM_THREADS;
	localparam int STACK_DEPTH = 2 * ($clog2(NUM_THREADS) + 1);

	logic started;
	logic [NUM_WARPS-1:0] active;
	logic [NUM_WARPS-1:0] stalled;
	logic [NUM_WARPS-1:0] locked;
	logic [NUM_WARPS-1:0] spawn_pending;
	logic [NUM_WARPS-1:0] no_split;
	logic [PC_WIDTH-1:0] pc_q [NUM_WARPS];
	logic [NUM_THREADS-1:0] mask_q [NUM_WARPS];
	logic [PC_WIDTH-1:0] spawn_pc;

	logic [NUM_WARPS-1:0] spawn_set;
	logic ctl_hit;
	logic do_split;
	logic do_join;
	logic [ENTRY_W-1:0] push_lo;
	logic [ENTRY_W-1:0] push_hi;
	logic [ENTRY_W-1:0] stack_top [NUM_WARPS];
	logic join_fall;
	logic [PC_WIDTH-1:0] join_pc;
	logic [NUM_THREADS-1:0] join_mask;

	// Nothing is eligible until the first cycle out of reset
	assign eligible = started ? (active & ~stalled & ~barrier_wait & ~locked) : '0;
	assign all_halted = ~|active;

	// Hold issue while execute is changing the picked warp
	assign ctl_hit = ctl.valid && (ctl.warp == pick_warp);
	assign issue_valid = pick_valid && !fetch_stall && !ctl_hit;
	assign issue_pc = spawn_pending[pick_warp] ? spawn_pc : pc_q[pick_warp];
	assign issue_mask = spawn_pending[pick_warp] ? NUM_THREADS'(1) : mask_q[pick_warp];

	always_comb begin
		for (int i = 0; i < NUM_WARPS; i++) begin
			spawn_set[i] = CNT_W'(i) < ctl.count;
		end
	end

	assign do_split = ctl.valid && (ctl.op == CTL_SPLIT) && (|ctl.later_mask);
	assign do_join = ctl.valid && (ctl.op == CTL_JOIN) && !no_split[ctl.warp];
	assign push_lo = {1'b1, {PC_WIDTH{1'b0}}, mask_q[ctl.warp]};
	assign push_hi = {1'b0, ctl.pc, ctl.later_mask};
	assign {join_fall, join_pc, join_mask} = stack_top[ctl.warp];

	generate
		for (genvar w = 0; w < NUM_WARPS; w++) begin : g_stack
			ipdom_stack #(
				.WIDTH(ENTRY_W),
				.DEPTH(STACK_DEPTH)
			) u_stack (
				.clk(clk),
				.reset(reset),
				.push(do_split && (ctl.warp == WID_W'(w))),
				.pop(do_join && (ctl.warp == WID_W'(w))),
				.push_lo(push_lo),
				.push_hi(push_hi),
				.top(stack_top[w])
			);
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (reset) begin
			started <= 1'b0;
			active <= NUM_WARPS'(1);
			stalled <= '0;
			locked <= '0;
			spawn_pending <= '0;
			no_split <= '0;
			pc_q[0] <= START_PC;
			mask_q[0] <= NUM_THREADS'(1);
		end else begin
			started <= 1'b1;
			if (issue_take) begin
				pc_q[pick_warp] <= issue_pc + PC_STEP;
				locked[pick_warp] <= 1'b1;
				// First issue of a spawned warp runs one thread
				if (spawn_pending[pick_warp]) begin
					spawn_pending[pick_warp] <= 1'b0;
					mask_q[pick_warp] <= NUM_THREADS'(1);
				end
			end
			if (release_valid) begin
				locked[release_warp] <= 1'b0;
			end
			if (ctl.valid) begin
				case (ctl.op)
					CTL_SPAWN: begin
						active <= spawn_set;
						spawn_pending <= spawn_set & ~NUM_WARPS'(1);
						spawn_pc <= ctl.pc;
					end
					CTL_HALT: active[ctl.warp] <= 1'b0;
					CTL_WSTALL: stalled[ctl.warp] <= 1'b1;
					CTL_TMC: begin
						mask_q[ctl.warp] <= ctl.mask;
						stalled[ctl.warp] <= 1'b0;
					end
					CTL_SPLIT: begin
						stalled[ctl.warp] <= 1'b0;
						if (|ctl.later_mask) begin
							mask_q[ctl.warp] <= ctl.mask;
						end else begin
							no_split[ctl.warp] <= 1'b1;
						end
					end
					CTL_JOIN: begin
						if (no_split[ctl.warp]) begin
							no_split[ctl.warp] <= 1'b0;
						end else begin
							if (!join_fall) begin
								pc_q[ctl.warp] <= join_pc;
							end
							mask_q[ctl.warp] <= join_mask;
						end
					end
					CTL_BRANCH: begin
						if (ctl.taken) begin
							pc_q[ctl.warp] <= ctl.pc;
						end
						stalled[ctl.warp] <= 1'b0;
					end
					// Barrier arrivals live in barrier_unit
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/warp_picker.sv */
`timescale 1ns/1ps
`default_nettype none

module warp_picker #(
	parameter int NUM_WARPS = gpu_arch_pkg::DEF_NUM_WARPS,
	localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
	input wire clk,
	input wire reset,
	input wire [NUM_WARPS-1:0] eligible,
	input wire advance,
	output logic pick_valid,
	output logic [WID_W-1:0] pick_warp
);
	logic [NUM_WARPS-1:0] visible;
	logic [NUM_WARPS-1:0] live;
	logic [NUM_WARPS-1:0] cand;
	logic [NUM_WARPS-1:0] pick_onehot;
	logic refill;

	// Snapshot counts as empty once none of it is still eligible
	assign live = visible & eligible;
	assign refill = ~|live;
	assign cand = refill ? eligible : live;
	assign pick_valid = |cand;

	// Lowest index wins
	always_comb begin
		pick_warp = '0;
		pick_onehot = '0;
		for (int i = NUM_WARPS - 1; i >= 0; i--) begin
			if (cand[i]) begin
				pick_warp = WID_W'(i);
				pick_onehot = '0;
				pick_onehot[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			visible <= '0;
		end else if (advance) begin
			if (refill) begin
				// Rest of the eligible set waits its turn
				visible <= eligible & ~pick_onehot;
			end else begin
				visible <= visible & ~pick_onehot;
			end
		end
	end

endmodule

`default_nettype wire

/* design/warp_sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

module warp_sched_top #(
	parameter int NUM_WARPS = gpu_arch_pkg::DEF_NUM_WARPS,
	parameter int NUM_THREADS = gpu_arch_pkg::DEF_NUM_THREADS,
	parameter int NUM_BARRIERS = gpu_arch_pkg::DEF_NUM_BARRIERS,
	localparam int WID_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1,
	localparam int BID_W = (NUM_BARRIERS > 1) ? $clog2(NUM_BARRIERS) : 1,
	localparam int CNT_W = $clog2(NUM_WARPS + 1)
) (
	input wire clk,
	input wire reset,
	input wire ctl_valid,
	input wire warp_ctl_pkg::ctl_op_e ctl_op,
	input wire [WID_W-1:0] ctl_warp,
	input wire [NUM_THREADS-1:0] ctl_mask,
	input wire [NUM_THREADS-1:0] ctl_later_mask,
	input wire [gpu_arch_pkg::PC_WIDTH-1:0] ctl_pc,
	input wire ctl_taken,
	input wire [BID_W-1:0] ctl_barrier_id,
	input wire [CNT_W-1:0] ctl_count,
	input wire release_valid,
	input wire [WID_W-1:0] release_warp,
	input wire fetch_stall,
	output wire issue_valid,
	output wire [WID_W-1:0] issue_warp,
	output wire [gpu_arch_pkg::PC_WIDTH-1:0] issue_pc,
	output wire [NUM_THREADS-1:0] issue_mask,
	output wire all_halted
);
	wire [NUM_WARPS-1:0] barrier_wait;
	wire [NUM_WARPS-1:0] eligible;
	wire pick_valid;

	warp_ctl_if #(
		.NUM_WARPS(NUM_WARPS),
		.NUM_THREADS(NUM_THREADS),
		.NUM_BARRIERS(NUM_BARRIERS)
	) ctl ();

	assign ctl.valid = ctl_valid;
	assign ctl.op = ctl_op;
	assign ctl.warp = ctl_warp;
	assign ctl.mask = ctl_mask;
	assign ctl.later_mask = ctl_later_mask;
	assign ctl.pc = ctl_pc;
	assign ctl.taken = ctl_taken;
	assign ctl.barrier_id = ctl_barrier_id;
	assign ctl.count = ctl_count;

	warp_table #(
		.NUM_WARPS(NUM_WARPS),
		.NUM_THREADS(NUM_THREADS)
	) u_table (
		.clk(clk),
		.reset(reset),
		.ctl(ctl.tbl),
		.barrier_wait(barrier_wait),
		.pick_valid(pick_valid),
		.pick_warp(issue_warp),
		.fetch_stall(fetch_stall),
		// An accepted issue commits the table and advances the picker
		.issue_take(issue_valid),
		.release_valid(release_valid),
		.release_warp(release_warp),
		.eligible(eligible),
		.issue_valid(issue_valid),
		.issue_pc(issue_pc),
		.issue_mask(issue_mask),
		.all_halted(all_halted)
	);

	barrier_unit #(
		.NUM_WARPS(NUM_WARPS),
		.NUM_BARRIERS(NUM_BARRIERS)
	) u_barrier (
		.clk(clk),
		.reset(reset),
		.ctl(ctl.barrier),
		.barrier_wait(barrier_wait)
	);

	warp_picker #(
		.NUM_WARPS(NUM_WARPS)
	) u_picker (
		.clk(clk),
		.reset(reset),
		.eligible(eligible),
		.advance(issue_valid),
		.pick_valid(pick_valid),
		.pick_warp(issue_warp)
	);

endmodule

`default_nettype wire

/* testbench/tb_sched_model.svh */
`ifndef TB_SCHED_MODEL_SVH
`define TB_SCHED_MODEL_SVH

localparam int STK_DEPTH = 8;

logic m_started;
logic [NW-1:0] m_active;
logic [NW-1:0] m_stalled;
logic [NW-1:0] m_locked;
logic [NW-1:0] m_pending;
logic [NW-1:0] m_nosplit;
logic [NW-1:0] m_visible;
logic [PC_WIDTH-1:0] m_pc [NW];
logic [NT-1:0] m_mask [NW];
logic [PC_WIDTH-1:0] m_spawn_pc;
logic [NW-1:0] m_bar [NB];
// Reconvergence entries per warp
logic m_stk_fall [NW][STK_DEPTH];
logic [PC_WIDTH-1:0] m_stk_pc [NW][STK_DEPTH];
logic [NT-1:0] m_stk_mask [NW][STK_DEPTH];
int m_sp [NW];

// Predicted outputs for the current cycle
logic exp_valid;
int exp_warp;
logic [PC_WIDTH-1:0] exp_pc;
logic [NT-1:0] exp_mask;
logic exp_halted;
logic [NW-1:0] exp_elig;
logic exp_refill;

task automatic model_reset();
	m_started = 1'b0;
	m_active = NW'(1);
	m_stalled = '0;
	m_locked = '0;
	m_pending = '0;
	m_nosplit = '0;
	m_visible = '0;
	m_spawn_pc = '0;
	for (int w = 0; w < NW; w++) begin
		m_pc[w] = '0;
		m_mask[w] = '0;
		m_sp[w] = 0;
	end
	m_pc[0] = START_PC;
	m_mask[0] = NT'(1);
	for (int b = 0; b < NB; b++) begin
		m_bar[b] = '0;
	end
endtask

task automatic model_predict();
	logic [NW-1:0] wait_any;
	logic [NW-1:0] cand;
	wait_any = '0;
	for (int b = 0; b < NB; b++) begin
		wait_any = wait_any | m_bar[b];
	end
	exp_elig = m_started ? (m_active & ~m_stalled & ~m_locked & ~wait_any) : '0;
	// Snapshot first, whole eligible set once the snapshot runs dry
	exp_refill = (m_visible & exp_elig) == '0;
	cand = exp_refill ? exp_elig : (m_visible & exp_elig);
	exp_warp = 0;
	for (int i = NW - 1; i >= 0; i--) begin
		if (cand[i]) begin
			exp_warp = i;
		end
	end
	exp_valid = (cand != '0) && !fetch_stall &&
		!(ctl_valid && (ctl_warp == WID_W'(exp_warp)));
	exp_pc = m_pending[exp_warp] ? m_spawn_pc : m_pc[exp_warp];
	exp_mask = m_pending[exp_warp] ? NT'(1) : m_mask[exp_warp];
	exp_halted = m_active == '0;
endtask

task automatic model_clock();
	logic [NW-1:0] onehot;
	int w;
	int b;
	int cnt;
	w = int'(ctl_warp);
	b = int'(ctl_barrier_id);
	if (exp_valid) begin
		onehot = '0;
		onehot[exp_warp] = 1'b1;
		m_visible = exp_refill ? (exp_elig & ~onehot) : (m_visible & ~onehot);
		m_pc[exp_warp] = exp_pc + PC_STEP;
		m_locked[exp_warp] = 1'b1;
		if (m_pending[exp_warp]) begin
			m_pending[exp_warp] = 1'b0;
			m_mask[exp_warp] = NT'(1);
		end
	end
	if (release_valid) begin
		m_locked[release_warp] = 1'b0;
	end
	m_started = 1'b1;
	if (ctl_valid) begin
		case (ctl_op)
			CTL_SPAWN: begin
				for (int i = 0; i < NW; i++) begin
					m_active[i] = i < int'(ctl_count);
				end
				m_pending = m_active & ~NW'(1);
				m_spawn_pc = ctl_pc;
			end
			CTL_HALT: m_active[w] = 1'b0;
			CTL_WSTALL: m_stalled[w] = 1'b1;
			CTL_TMC: begin
				m_mask[w] = ctl_mask;
				m_stalled[w] = 1'b0;
			end
			CTL_SPLIT: begin
				m_stalled[w] = 1'b0;
				if (ctl_later_mask != '0) begin
					m_stk_fall[w][m_sp[w]] = 1'b1;
					m_stk_pc[w][m_sp[w]] = '0;
					m_stk_mask[w][m_sp[w]] = m_mask[w];
					m_stk_fall[w][m_sp[w] + 1] = 1'b0;
					m_stk_pc[w][m_sp[w] + 1] = ctl_pc;
					m_stk_mask[w][m_sp[w] + 1] = ctl_later_mask;
					m_sp[w] = m_sp[w] + 2;
					m_mask[w] = ctl_mask;
				end else begin
					m_nosplit[w] = 1'b1;
				end
			end
			CTL_JOIN: begin
				if (m_nosplit[w]) begin
					m_nosplit[w] = 1'b0;
				end else begin
					m_sp[w] = m_sp[w] - 1;
					if (!m_stk_fall[w][m_sp[w]]) begin
						m_pc[w] = m_stk_pc[w][m_sp[w]];
					end
					m_mask[w] = m_stk_mask[w][m_sp[w]];
				end
			end
			CTL_BRANCH: begin
				if (ctl_taken) begin
					m_pc[w] = ctl_pc;
				end
				m_stalled[w] = 1'b0;
			end
			CTL_BARRIER: begin
				cnt = 0;
				for (int i = 0; i < NW; i++) begin
					cnt = cnt + int'(m_bar[b][i]);
				end
				// Last arrival frees the whole barrier
				if (cnt + 1 == int'(ctl_count)) begin
					m_bar[b] = '0;
				end else begin
					m_bar[b][w] = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end
endtask

`endif

/* testbench/tb_warp_sched.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_warp_sched;
	import gpu_arch_pkg::*;
	import warp_ctl_pkg::*;

	localparam int NW = DEF_NUM_WARPS;
	localparam int NT = DEF_NUM_THREADS;
	localparam int NB = DEF_NUM_BARRIERS;
	localparam int WID_W = (NW > 1) ? $clog2(NW) : 1;
	localparam int BID_W = (NB > 1) ? $clog2(NB) : 1;
	localparam int CNT_W = $clog2(NW + 1);
	localparam int CLK_PERIOD = 40;
	localparam int WAIT_LIMIT = 20;
	localparam int RANDOM_CYCLES = 4000;

	logic clk;
	logic reset;
	logic ctl_valid;
	ctl_op_e ctl_op;
	logic [WID_W-1:0] ctl_warp;
	logic [NT-1:0] ctl_mask;
	logic [NT-1:0] ctl_later_mask;
	logic [PC_WIDTH-1:0] ctl_pc;
	logic ctl_taken;
	logic [BID_W-1:0] ctl_barrier_id;
	logic [CNT_W-1:0] ctl_count;
	logic release_valid;
	logic [WID_W-1:0] release_warp;
	logic fetch_stall;
	wire issue_valid;
	wire [WID_W-1:0] issue_warp;
	wire [PC_WIDTH-1:0] issue_pc;
	wire [NT-1:0] issue_mask;
	wire all_halted;

	logic [15:0] lfsr_state;
	int value_errors;
	int timeout_errors;
	// DUT outputs seen in the last checked cycle
	logic seen_valid;
	logic [PC_WIDTH-1:0] seen_pc;
	logic seen_halted;

	`include "tb_sched_model.svh"

	warp_sched_top #(
		.NUM_WARPS(NW),
		.NUM_THREADS(NT),
		.NUM_BARRIERS(NB)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.ctl_valid(ctl_valid),
		.ctl_op(ctl_op),
		.ctl_warp(ctl_warp),
		.ctl_mask(ctl_mask),
		.ctl_later_mask(ctl_later_mask),
		.ctl_pc(ctl_pc),
		.ctl_taken(ctl_taken),
		.ctl_barrier_id(ctl_barrier_id),
		.ctl_count(ctl_count),
		.release_valid(release_valid),
		.release_warp(release_warp),
		.fetch_stall(fetch_stall),
		.issue_valid(issue_valid),
		.issue_warp(issue_warp),
		.issue_pc(issue_pc),
		.issue_mask(issue_mask),
		.all_halted(all_halted)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// 16-bit Fibonacci LFSR on taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = (r << 1) | int'(lfsr_state[0]);
		end
		return r;
	endfunction

	task automatic idle_inputs();
		ctl_valid = 1'b0;
		ctl_op = CTL_NONE;
		ctl_warp = '0;
		ctl_mask = '0;
		ctl_later_mask = '0;
		ctl_pc = '0;
		ctl_taken = 1'b0;
		ctl_barrier_id = '0;
		ctl_count = '0;
		release_valid = 1'b0;
		release_warp = '0;
		fetch_stall = 1'b0;
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] expv);
		value_errors++;
		$display("FAIL t=%0t: %s got %0h expected %0h", $time, name, got, expv);
	endtask

	// Sample mid-cycle, compare, then step the model over the next edge
	task automatic check_cycle();
		#(CLK_PERIOD / 4);
		model_predict();
		if (issue_valid !== exp_valid) begin
			report_value("issue_valid", 32'(issue_valid), 32'(exp_valid));
		end
		if (exp_valid && issue_warp !== WID_W'(exp_warp)) begin
			report_value("issue_warp", 32'(issue_warp), 32'(exp_warp));
		end
		if (exp_valid && issue_pc !== exp_pc) begin
			report_value("issue_pc", issue_pc, exp_pc);
		end
		if (exp_valid && issue_mask !== exp_mask) begin
			report_value("issue_mask", 32'(issue_mask), 32'(exp_mask));
		end
		if (all_halted !== exp_halted) begin
			report_value("all_halted", 32'(all_halted), 32'(exp_halted));
		end
		seen_valid = issue_valid;
		seen_pc = issue_pc;
		seen_halted = all_halted;
		model_clock();
		@(negedge clk);
	endtask

	task automatic wait_for(input logic want_halt, input string what);
		int n;
		n = 0;
		do begin
			check_cycle();
			n++;
		end while (!(want_halt ? seen_halted : seen_valid) && n < WAIT_LIMIT);
		if (!(want_halt ? seen_halted : seen_valid)) begin
			timeout_errors++;
			$display("Timeout at %0t: %s", $time, what);
		end
	endtask

	// Illegal split or join events go out with valid low
	task automatic drive_event(input int w, input int r);
		ctl_warp = WID_W'(w);
		ctl_pc = 32'h8000_1000 + 32'(rand_bits(8) << 2);
		ctl_mask = NT'(rand_bits(NT));
		ctl_later_mask = (rand_bits(2) == 0) ? '0 : NT'(rand_bits(NT));
		ctl_taken = rand_bits(1) != 0;
		ctl_barrier_id = BID_W'(rand_bits(BID_W));
		ctl_count = CNT_W'(1 + rand_bits(2));
		ctl_valid = 1'b1;
		if (r == 0) begin
			ctl_op = CTL_SPAWN;
		end else if (r == 1) begin
			ctl_op = CTL_HALT;
		end else if (r < 4) begin
			ctl_op = CTL_WSTALL;
		end else if (r < 6) begin
			ctl_op = CTL_TMC;
		end else if (r < 8) begin
			ctl_op = CTL_SPLIT;
			ctl_valid = !m_pending[w] && (ctl_later_mask == '0 || m_sp[w] <= 4);
		end else if (r < 10) begin
			ctl_op = CTL_JOIN;
			ctl_valid = !m_pending[w] && (m_nosplit[w] || m_sp[w] > 0);
		end else if (r < 13) begin
			ctl_op = CTL_BRANCH;
		end else begin
			ctl_op = CTL_BARRIER;
		end
	endtask

	task automatic drive_random();
		int w;
		idle_inputs();
		fetch_stall = rand_bits(3) == 0;
		w = rand_bits(WID_W) % NW;
		// Fetch hands locked warps back after a random delay
		if (rand_bits(2) == 0 && m_locked[w]) begin
			release_valid = 1'b1;
			release_warp = WID_W'(w);
		end
		w = rand_bits(WID_W) % NW;
		if (m_active == '0) begin
			drive_event(w, 0);
		end else if (rand_bits(2) == 0 && m_active[w]) begin
			drive_event(w, rand_bits(4));
		end
	endtask

	initial begin
		lfsr_state = 16'd41;
		value_errors = 0;
		timeout_errors = 0;
		idle_inputs();
		reset = 1'b1;
		// Nothing may issue while reset is held
		repeat (3) begin
			@(posedge clk);
			#(CLK_PERIOD / 4);
			if (issue_valid !== 1'b0) begin
				report_value("issue_valid during reset", 32'(issue_valid), 32'd0);
			end
		end
		@(negedge clk);
		reset = 1'b0;
		model_reset();

		wait_for(1'b0, "warp 0 never issued after reset");
		if (seen_pc !== START_PC) begin
			report_value("first issue_pc", seen_pc, START_PC);
		end
		// Locked until fetch releases it
		repeat (5) begin
			check_cycle();
			if (seen_valid) begin
				report_value("issue while warp 0 locked", 32'(seen_valid), 32'd0);
			end
		end
		release_valid = 1'b1;
		release_warp = '0;
		check_cycle();
		idle_inputs();
		wait_for(1'b0, "warp 0 never issued after release");
		if (seen_pc !== START_PC + PC_STEP) begin
			report_value("second issue_pc", seen_pc, START_PC + PC_STEP);
		end

		repeat (RANDOM_CYCLES) begin
			drive_random();
			check_cycle();
		end

		for (int w = 0; w < NW; w++) begin
			idle_inputs();
			ctl_valid = 1'b1;
			ctl_op = CTL_HALT;
			ctl_warp = WID_W'(w);
			check_cycle();
		end
		idle_inputs();
		wait_for(1'b1, "all_halted never rose after halting every warp");
		repeat (5) begin
			check_cycle();
			if (seen_valid) begin
				report_value("issue after all halted", 32'(seen_valid), 32'd0);
			end
		end

		$display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* warp_sched_top.f */
+incdir+testbench
design/gpu_arch_pkg.sv
design/warp_ctl_pkg.sv
design/warp_ctl_if.sv
design/ipdom_stack.sv
design/barrier_unit.sv
design/warp_table.sv
design/warp_picker.sv
design/warp_sched_top.sv
testbench/tb_warp_sched.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the warp scheduler testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
	--top-module tb_warp_sched \
	-f warp_sched_top.f \
	-o sim_warp_sched

./obj_dir/sim_warp_sched | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
exit 1
